//--- source/menu_config.svh
/*
 * Screen geometry, slot counts, glyph codes and RGB565 colours for the
 * keyboard menu. Include it in any module that needs these constants.
 */
`ifndef MENU_CONFIG_SVH
`define MENU_CONFIG_SVH

// ----------------------------------------------------------------------
// slot layout, 16x8 font on a 160x128 landscape panel
// ----------------------------------------------------------------------
`define MENU_CHAR_NUM       7'd108      // slots per screen
`define MENU_TITLE_LEN      7'd8        // "KeyBoard"
`define MENU_ROW_CHARS      7'd20       // 160 / 8
`define MENU_SCALE_BASE     7'd8        // first slot of LOW row
`define MENU_SAMPLE_BASE    7'd68       // first slot of SAMPLE line
`define MENU_SCORE_FIRST    7'd91       // first shown note
`define MENU_TITLE_X0       9'd48       // centres the 8-char title

// ----------------------------------------------------------------------
// glyph codes, font index is ascii minus 32
// ----------------------------------------------------------------------
`define GLYPH_ASCII_OFS     8'd32
`define GLYPH_SPACE         8'd0
`define GLYPH_LT            8'd28
`define GLYPH_GT            8'd30
`define GLYPH_COLON         8'd26
`define GLYPH_DASH          8'd13
`define GLYPH_DIGIT0        8'd16

// ----------------------------------------------------------------------
// colours
// ----------------------------------------------------------------------
`define COLOR_LABEL         16'h815B
`define COLOR_KEY_HIT       16'hFA20
`define COLOR_ROW           16'hAF7D
`define COLOR_SAMPLE        16'hF810
`define COLOR_NAME          16'h97F9
`define COLOR_NOTE_BG       16'hBFD9
`define COLOR_PANEL         16'hE73F
`define COLOR_WHITE         16'hFFFF
`define COLOR_BLACK         16'h0000

`define KEY_PREV_SONG       4'hF
`define KEY_NEXT_SONG       4'hE

`endif

//--- source/song_table.svh
/*
 * Built-in practice songs. Notes are octal digits with the first note in
 * the lowest digit; names are eight ASCII bytes, first character on top.
 */
`ifndef SONG_TABLE_SVH
`define SONG_TABLE_SVH

`define SONG0_NOTES 351'o35321235321212122335356532112532132355235321323551212233535653211253213235523532132355
`define SONG0_LEN   7'd86
`define SONG0_NAME  64'h2020514843202020

`define SONG1_NOTES 351'o1642624616426122146622146611353645123213111353645123213112214662214665366332765617113536451232131113536451232131
`define SONG1_LEN   7'd112
`define SONG1_NAME  64'h2020433431382020

`define SONG2_NOTES 351'o5612322352332363233235713332265633656335365636712612333226563365633536563
`define SONG2_LEN   7'd73
`define SONG2_NAME  64'h2020205A48202020

`define SONG3_NOTES 351'o3335422216656211234321213443521665621123424565654421222611212225441222245656654212216121225442122
`define SONG3_LEN   7'd97
`define SONG3_NAME  64'h2020514259202020

`endif

//--- source/menu_pkg.sv
/*
 * Shared types of the keyboard menu. Modules pull them in with a
 * wildcard import in their header.
 */
`default_nettype none

package menu_pkg;

    typedef logic [7:0]  glyph_t;       // font index
    typedef logic [8:0]  coord_t;       // pixel coordinate
    typedef logic [15:0] color_t;       // rgb565
    typedef logic [6:0]  slot_t;        // 0..107
    typedef logic [2:0]  note_t;
    typedef logic [1:0]  song_sel_t;
    typedef logic [6:0]  song_len_t;
    typedef logic [7:0][7:0] song_name_t;   // byte 7 is the first char

    // 117 notes of 3 bits; shifted as a whole, indexed by position
    typedef union packed {
        logic [350:0]      flat;
        note_t [116:0]     notes;
    } score_u;

endpackage

`default_nettype wire

//--- source/score_view_if.sv
/*
 * Practice state published by the tracker and read by the glyph and
 * colour stages.
 */
`default_nettype none

interface score_view_if import menu_pkg::*; ();

    score_u     score;          // notes[0] is the expected note
    song_len_t  remaining;      // notes left before wrap
    song_name_t name;

    modport tracker (output score, output remaining, output name);
    modport view    (input score, input remaining, input name);

endinterface

`default_nettype wire

//--- source/char_sequencer.sv
/*
 * Paces the LCD character writer. Emits a draw request every fourth
 * cycle and steps the character slot on each completed character.
 */
`default_nettype none
`include "menu_config.svh"

module char_sequencer import menu_pkg::*; (
    input  wire   sys_clk,
    input  wire   sys_rst_n,
    input  wire   init_done,
    input  wire   show_char_done,
    output logic  show_char_flag,
    output slot_t slot
);

    logic [1:0] dly_cnt;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            dly_cnt <= 2'd0;
        end else if (init_done) begin
            dly_cnt <= dly_cnt + 2'd1;      // wraps every 4
        end else begin
            dly_cnt <= 2'd0;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            show_char_flag <= 1'b0;
        end else begin
            show_char_flag <= init_done && (dly_cnt == 2'd3);
        end
    end

    // writer pulses done for one cycle per character
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            slot <= '0;
        end else if (init_done && show_char_done) begin
            slot <= (slot == `MENU_CHAR_NUM - 7'd1) ? '0 : slot + 7'd1;
        end
    end

endmodule

`default_nettype wire

//--- source/practice_tracker.sv
/*
 * Key-press FSM for the practice line. The right note advances the
 * score, F and E step through the built-in songs.
 */
`default_nettype none
`include "menu_config.svh"
`include "song_table.svh"

module practice_tracker import menu_pkg::*; (
    input  wire           sys_clk,
    input  wire           sys_rst_n,
    input  wire           init_done,
    input  wire           is_pressed,
    input  wire     [3:0] keyboard_data,
    score_view_if.tracker sv
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_PRESSED = 3'd1;
    localparam logic [2:0] ST_JUDGE   = 3'd2;
    localparam logic [2:0] ST_ADVANCE = 3'd3;
    localparam logic [2:0] ST_SELECT  = 3'd4;
    localparam logic [2:0] ST_LOAD    = 3'd5;
    localparam logic [2:0] ST_HOLD    = 3'd6;

    logic [2:0] state;
    logic [3:0] key_q;
    song_sel_t  song_sel;
    score_u     rom_score;
    song_len_t  rom_len;
    song_name_t rom_name;

    // song table lookup
    always_comb begin
        case (song_sel)
            2'd0: begin
                rom_score.flat = `SONG0_NOTES;
                rom_len        = `SONG0_LEN;
                rom_name       = `SONG0_NAME;
            end
            2'd1: begin
                rom_score.flat = `SONG1_NOTES;
                rom_len        = `SONG1_LEN;
                rom_name       = `SONG1_NAME;
            end
            2'd2: begin
                rom_score.flat = `SONG2_NOTES;
                rom_len        = `SONG2_LEN;
                rom_name       = `SONG2_NAME;
            end
            default: begin
                rom_score.flat = `SONG3_NOTES;
                rom_len        = `SONG3_LEN;
                rom_name       = `SONG3_NAME;
            end
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (state == ST_PRESSED) begin
            key_q <= keyboard_data;         // key as seen one cycle after press
        end
    end

    // ------------------------------------------------------------------
    // FSM and practice state
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state          <= ST_IDLE;
            song_sel       <= 2'd0;
            sv.score.flat  <= `SONG0_NOTES;
            sv.remaining   <= `SONG0_LEN;
            sv.name        <= `SONG0_NAME;
        end else if (init_done) begin
            case (state)
                ST_IDLE:    state <= is_pressed ? ST_PRESSED : ST_IDLE;
                ST_PRESSED: state <= ST_JUDGE;
                ST_JUDGE: begin
                    if (key_q == {1'b0, sv.score.notes[0]}) begin
                        state <= ST_ADVANCE;
                    end else if (key_q == `KEY_PREV_SONG || key_q == `KEY_NEXT_SONG) begin
                        state <= ST_SELECT;
                    end else begin
                        state <= ST_HOLD;
                    end
                end
                ST_ADVANCE: begin
                    if (sv.remaining <= 7'd1) begin     // last note hit, start over
                        sv.score     <= rom_score;
                        sv.remaining <= rom_len;
                    end else begin
                        sv.score.flat <= sv.score.flat >> 3;
                        sv.remaining  <= sv.remaining - 7'd1;
                    end
                    state <= ST_HOLD;
                end
                ST_SELECT: begin
                    song_sel <= (key_q == `KEY_PREV_SONG) ? song_sel - 2'd1 : song_sel + 2'd1;
                    state    <= ST_LOAD;
                end
                ST_LOAD: begin
                    sv.score     <= rom_score;          // table already follows song_sel
                    sv.remaining <= rom_len;
                    sv.name      <= rom_name;
                    state        <= ST_HOLD;
                end
                default:    state <= is_pressed ? ST_HOLD : ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/glyph_mapper.sv
/*
 * Translates the current slot into a font index for the keyboard screen:
 * title, scale rows, sample line, song name and the upcoming notes.
 */
`default_nettype none
`include "menu_config.svh"

module glyph_mapper import menu_pkg::*; (
    input  wire        sys_clk,
    input  wire        sys_rst_n,
    input  wire        init_done,
    input  wire slot_t slot,
    input  wire  [1:0] scale,
    score_view_if.view sv,
    output glyph_t     ascii_num
);

    localparam logic [0:7][7:0]      TITLE_TXT  = "KeyBoard";
    localparam logic [0:2][0:2][7:0] ROW_TXT    = {"LOW", "MID", "HIG"};
    localparam logic [0:5][7:0]      SAMPLE_TXT = "SAMPLE";

    slot_t  rel;
    slot_t  row;
    slot_t  col;
    slot_t  pos;
    glyph_t glyph_next;

    always_comb begin
        rel        = slot - `MENU_SCALE_BASE;
        row        = rel / `MENU_ROW_CHARS;
        col        = rel % `MENU_ROW_CHARS;
        pos        = (slot - `MENU_SCORE_FIRST) >> 1;   // note position
        glyph_next = `GLYPH_SPACE;
        if (slot < `MENU_TITLE_LEN) begin
            glyph_next = TITLE_TXT[slot[2:0]] - `GLYPH_ASCII_OFS;
        end else if (slot < `MENU_SAMPLE_BASE) begin
            if (col < 7'd3) begin
                glyph_next = ROW_TXT[row[1:0]][col[1:0]] - `GLYPH_ASCII_OFS;
            end else if (col == 7'd3) begin
                glyph_next = `GLYPH_GT;
            end else if (col == 7'd19) begin
                glyph_next = (row == slot_t'(scale)) ? `GLYPH_LT : `GLYPH_SPACE;
            end else if (col[0]) begin
                glyph_next = `GLYPH_DIGIT0 + glyph_t'((col - 7'd3) >> 1);   // 1..7
            end
        end else if (slot < 7'd74) begin
            glyph_next = SAMPLE_TXT[3'(slot - `MENU_SAMPLE_BASE)] - `GLYPH_ASCII_OFS;
        end else begin
            case (slot)
                7'd74:   glyph_next = `GLYPH_COLON;
                7'd76:   glyph_next = `GLYPH_GT;
                7'd78:   glyph_next = `GLYPH_LT;
                7'd88:   glyph_next = `GLYPH_DASH;
                7'd89:   glyph_next = `GLYPH_GT;
                7'd77: begin
                    case (scale)
                        2'd0:    glyph_next = "L" - `GLYPH_ASCII_OFS;
                        2'd1:    glyph_next = "M" - `GLYPH_ASCII_OFS;
                        default: glyph_next = "H" - `GLYPH_ASCII_OFS;
                    endcase
                end
                default: begin
                    if (slot >= 7'd80 && slot <= 7'd87) begin
                        glyph_next = sv.name[3'(7'd87 - slot)] - `GLYPH_ASCII_OFS;
                    end else if (slot >= `MENU_SCORE_FIRST && slot[0]) begin
                        glyph_next = (pos < sv.remaining) ?
                                     `GLYPH_DIGIT0 + glyph_t'(sv.score.notes[pos]) :
                                     `GLYPH_SPACE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ascii_num <= `GLYPH_SPACE;
        end else if (init_done) begin
            ascii_num <= glyph_next;
        end else begin
            ascii_num <= `GLYPH_SPACE;
        end
    end

endmodule

`default_nettype wire

//--- source/char_style.sv
/*
 * Picks background and foreground colour per slot. A held key 1-7 lights
 * its digit in the active scale row; the next expected note is marked.
 */
`default_nettype none
`include "menu_config.svh"

module char_style import menu_pkg::*; (
    input  wire        sys_clk,
    input  wire        sys_rst_n,
    input  wire        init_done,
    input  wire slot_t slot,
    input  wire  [1:0] scale,
    input  wire        is_pressed,
    input  wire  [3:0] keyboard_data,
    score_view_if.view sv,
    output color_t     background_color,
    output color_t     front_color
);

    slot_t  rel;
    slot_t  row;
    slot_t  col;
    logic   key_hit;
    color_t bg_next;
    color_t fg_next;

    always_comb begin
        rel     = slot - `MENU_SCALE_BASE;
        row     = rel / `MENU_ROW_CHARS;
        col     = rel % `MENU_ROW_CHARS;
        // each digit owns the blank before it and itself
        key_hit = is_pressed && (keyboard_data inside {[4'd1:4'd7]}) &&
                  row == slot_t'(scale) && col >= 7'd4 &&
                  ((col - 7'd4) >> 1) + 7'd1 == slot_t'(keyboard_data);
        bg_next = `COLOR_PANEL;
        fg_next = `COLOR_BLACK;
        if (slot < `MENU_SAMPLE_BASE) begin
            bg_next = `COLOR_ROW;
            if (slot >= `MENU_SCALE_BASE && col < 7'd3) begin  // LOW/MID/HIG
                bg_next = `COLOR_LABEL;
                fg_next = `COLOR_WHITE;
            end else if (slot >= `MENU_SCALE_BASE && key_hit) begin
                bg_next = `COLOR_KEY_HIT;
                fg_next = `COLOR_WHITE;
            end
        end else if (slot < 7'd75) begin                        // SAMPLE:
            bg_next = `COLOR_SAMPLE;
            fg_next = `COLOR_WHITE;
        end else if (slot == 7'd77) begin                       // scale letter
            bg_next = `COLOR_LABEL;
            fg_next = `COLOR_WHITE;
        end else if (slot >= 7'd80 && slot <= 7'd87) begin
            bg_next = `COLOR_NAME;
        end else if (slot == `MENU_SCORE_FIRST && sv.remaining != 7'd0) begin
            bg_next = `COLOR_NOTE_BG;
            fg_next = `COLOR_LABEL;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            background_color <= `COLOR_WHITE;
            front_color      <= `COLOR_BLACK;
        end else if (init_done) begin
            background_color <= bg_next;
            front_color      <= fg_next;
        end else begin
            background_color <= `COLOR_WHITE;
            front_color      <= `COLOR_BLACK;
        end
    end

endmodule

`default_nettype wire

//--- source/char_placement.sv
/*
 * Converts the slot into the top-left pixel of its character cell.
 */
`default_nettype none
`include "menu_config.svh"

module char_placement import menu_pkg::*; (
    input  wire        sys_clk,
    input  wire        sys_rst_n,
    input  wire        init_done,
    input  wire slot_t slot,
    output coord_t     start_x,
    output coord_t     start_y
);

    slot_t  rel;
    slot_t  row;
    slot_t  col;
    coord_t x_next;
    coord_t y_next;

    always_comb begin
        rel = slot - `MENU_SCALE_BASE;
        row = rel / `MENU_ROW_CHARS;        // 0..2 scale rows, 3..4 sample
        col = rel % `MENU_ROW_CHARS;
        if (slot < `MENU_TITLE_LEN) begin
            x_next = `MENU_TITLE_X0 + (coord_t'(slot) << 3);
            y_next = 9'd0;
        end else begin
            x_next = 9'd1 + (coord_t'(col) << 3);   // 1 px off the left edge
            // one blank line after the title, one more before sample
            y_next = ((row < 7'd3) ? 9'd32 : 9'd48) + (coord_t'(row) << 4);
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            start_x <= '0;
            start_y <= '0;
        end else if (init_done) begin
            start_x <= x_next;
            start_y <= y_next;
        end else begin
            start_x <= '0;
            start_y <= '0;
        end
    end

endmodule

`default_nettype wire

//--- source/menu_show_top.sv
/*
 * Keyboard menu generator for the LCD character writer. Feeds one glyph,
 * position and colour pair per character slot.
 */
`default_nettype none

module menu_show_top import menu_pkg::*; (
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         init_done,
    input  wire         show_char_done,
    input  wire         is_pressed,
    input  wire   [3:0] keyboard_data,
    input  wire   [1:0] scale,
    output wire         show_char_flag,
    output wire glyph_t ascii_num,
    output wire coord_t start_x,
    output wire coord_t start_y,
    output wire color_t background_color,
    output wire color_t front_color
);

    slot_t slot;

    score_view_if i_view ();

    char_sequencer i_seq (
        .sys_clk, .sys_rst_n, .init_done, .show_char_done,
        .show_char_flag, .slot
    );

    practice_tracker i_tracker (
        .sys_clk, .sys_rst_n, .init_done, .is_pressed, .keyboard_data,
        .sv (i_view.tracker)
    );

    glyph_mapper i_glyph (
        .sys_clk, .sys_rst_n, .init_done, .slot, .scale,
        .sv (i_view.view), .ascii_num
    );

    char_style i_style (
        .sys_clk, .sys_rst_n, .init_done, .slot, .scale, .is_pressed, .keyboard_data,
        .sv (i_view.view), .background_color, .front_color
    );

    char_placement i_place (
        .sys_clk, .sys_rst_n, .init_done, .slot, .start_x, .start_y
    );

endmodule

`default_nettype wire

//--- test/tb_menu_model.svh
/*
 * Expected glyph, colour and position per character slot of the keyboard
 * screen, plus the LFSR for random gaps. Included inside the testbench.
 */
`ifndef TB_MENU_MODEL_SVH
`define TB_MENU_MODEL_SVH

// ----------------------------------------------------------------------
// song table access
// ----------------------------------------------------------------------
function automatic logic [350:0] song_notes(input int sel);
    case (sel)
        0:       return `SONG0_NOTES;
        1:       return `SONG1_NOTES;
        2:       return `SONG2_NOTES;
        default: return `SONG3_NOTES;
    endcase
endfunction

function automatic int song_len(input int sel);
    case (sel)
        0:       return `SONG0_LEN;
        1:       return `SONG1_LEN;
        2:       return `SONG2_LEN;
        default: return `SONG3_LEN;
    endcase
endfunction

function automatic logic [63:0] song_name(input int sel);
    case (sel)
        0:       return `SONG0_NAME;
        1:       return `SONG1_NAME;
        2:       return `SONG2_NAME;
        default: return `SONG3_NAME;
    endcase
endfunction

// ----------------------------------------------------------------------
// screen content
// ----------------------------------------------------------------------
function automatic logic [7:0] exp_glyph(input int s, input int scl, input int song,
                                         input int ofs);
    string title;
    string labels;
    string sample;
    int r;
    int c;
    int p;
    logic [350:0] nts;
    logic [63:0] nm;
    title  = "KeyBoard";
    labels = "LOWMIDHIG";
    sample = "SAMPLE";
    r      = (s - 8) / 20;
    c      = (s - 8) % 20;
    p      = ofs + (s - 91) / 2;        // song index of the shown note
    nts    = song_notes(song);
    nm     = song_name(song);
    if (s < 8) return title[s] - 8'd32;
    if (s < 68) begin
        if (c < 3) return labels[r * 3 + c] - 8'd32;
        if (c == 3) return ">" - 8'd32;
        if (c == 19) return (r == scl) ? "<" - 8'd32 : 8'd0;
        if (c % 2 == 1) return "0" - 8'd32 + 8'((c - 3) / 2);
        return 8'd0;
    end
    if (s < 74) return sample[s - 68] - 8'd32;
    if (s == 74) return ":" - 8'd32;
    if (s == 76) return ">" - 8'd32;
    if (s == 77) return (scl == 0) ? "L" - 8'd32 : (scl == 1) ? "M" - 8'd32 : "H" - 8'd32;
    if (s == 78) return "<" - 8'd32;
    if (s >= 80 && s <= 87) return nm[63 - 8 * (s - 80) -: 8] - 8'd32;
    if (s == 88) return "-" - 8'd32;
    if (s == 89) return ">" - 8'd32;
    if (s >= 91 && s % 2 == 1 && p < song_len(song)) return 8'd16 + 8'(nts[3 * p +: 3]);
    return 8'd0;
endfunction

// {background, foreground}
function automatic logic [31:0] exp_colors(input int s, input int scl, input logic pressed,
                                           input int key, input int remaining);
    int r;
    int c;
    r = (s - 8) / 20;
    c = (s - 8) % 20;
    if (s < 68) begin
        if (s >= 8 && c < 3) return {`COLOR_LABEL, `COLOR_WHITE};
        if (s >= 8 && pressed && key >= 1 && key <= 7 && r == scl &&
            (c == 2 * key + 2 || c == 2 * key + 3)) return {`COLOR_KEY_HIT, `COLOR_WHITE};
        return {`COLOR_ROW, `COLOR_BLACK};
    end
    if (s < 75) return {`COLOR_SAMPLE, `COLOR_WHITE};
    if (s == 77) return {`COLOR_LABEL, `COLOR_WHITE};
    if (s >= 80 && s <= 87) return {`COLOR_NAME, `COLOR_BLACK};
    if (s == 91 && remaining != 0) return {`COLOR_NOTE_BG, `COLOR_LABEL};
    return {`COLOR_PANEL, `COLOR_BLACK};
endfunction

function automatic logic [8:0] exp_x(input int s);
    return (s < 8) ? 9'(48 + 8 * s) : 9'(1 + 8 * ((s - 8) % 20));
endfunction

function automatic logic [8:0] exp_y(input int s);
    int r;
    r = (s - 8) / 20;
    if (s < 8) return 9'd0;
    if (r < 3) return 9'(32 + 16 * r);
    return (r == 3) ? 9'd96 : 9'd112;       // two sample lines
endfunction

// galois form, taps for x^8+x^6+x^5+x^4+1
function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
endfunction

`endif

//--- test/tb_menu_show.sv
/*
 * Testbench for the keyboard menu generator. Acts as the LCD character
 * writer, scans whole frames and presses keys, checking against the model.
 */
`default_nettype none
`include "menu_config.svh"
`include "song_table.svh"

module tb_menu_show;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        init_done;
    logic        show_char_done;
    logic        is_pressed;
    logic  [3:0] keyboard_data;
    logic  [1:0] scale;
    wire         show_char_flag;
    wire   [7:0] ascii_num;
    wire   [8:0] start_x;
    wire   [8:0] start_y;
    wire  [15:0] background_color;
    wire  [15:0] front_color;

    int         cur_song;       // model of the practice state
    int         cur_ofs;
    int         exp_slot;
    logic [7:0] lfsr;
    int         errors;
    int         tests;
    int         tests_failed;
    bit         timed_out;

    `include "tb_menu_model.svh"

    menu_show_top i_dut (
        .sys_clk, .sys_rst_n, .init_done, .show_char_done, .is_pressed,
        .keyboard_data, .scale, .show_char_flag, .ascii_num, .start_x, .start_y,
        .background_color, .front_color
    );

    always #50 sys_clk = ~sys_clk;

    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                     show_char_flag |=> !show_char_flag)
        else report_bad("draw request longer than one cycle", 64'd0, 64'd1);

    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                     !init_done |=> !show_char_flag)
        else report_bad("draw request before init", 64'd0, 64'd1);

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic report_bad(input string what, input logic [63:0] e, input logic [63:0] a);
        errors++;
        $display("FAILED %0t: slot %0d %s expected %0h got %0h", $time, exp_slot, what, e, a);
    endtask

    task automatic next_cycle;
        @(posedge sys_clk);
        #10;                                // drive and sample point
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic rand_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic wait_draw_request;
        int n;
        n = 0;
        while (!show_char_flag && n < 8) begin
            next_cycle();
            n++;
        end
        if (!show_char_flag) begin
            timed_out = 1;
            $display("timeout at %0t: no draw request from the DUT within 8 cycles", $time);
        end
    endtask

    task automatic step_slot;
        int gap;
        wait_draw_request();
        if (timed_out) return;
        rand_bits(2, gap);
        idle_cycles(gap);
        show_char_done = 1'b1;
        next_cycle();
        show_char_done = 1'b0;
        next_cycle();                       // outputs now hold the next slot
        exp_slot = (exp_slot + 1) % 108;
    endtask

    task automatic check_slot;
        logic [7:0]  g;
        logic [31:0] col;
        g   = exp_glyph(exp_slot, scale, cur_song, cur_ofs);
        col = exp_colors(exp_slot, scale, is_pressed, keyboard_data,
                         song_len(cur_song) - cur_ofs);
        assert (ascii_num == g) else report_bad("glyph", g, ascii_num);
        assert (start_x == exp_x(exp_slot)) else report_bad("x", exp_x(exp_slot), start_x);
        assert (start_y == exp_y(exp_slot)) else report_bad("y", exp_y(exp_slot), start_y);
        assert ({background_color, front_color} == col)
            else report_bad("colours", col, {background_color, front_color});
    endtask

    task automatic scan_frame;              // ends on the slot it started from
        repeat (`MENU_CHAR_NUM) begin
            if (!timed_out) begin
                check_slot();
                step_slot();
            end
        end
    endtask

    function automatic int note_now();
        logic [350:0] nts;
        nts = song_notes(cur_song);
        return int'(nts[3 * cur_ofs +: 3]);
    endfunction

    task automatic key_down(input logic [3:0] k);
        keyboard_data = k;
        is_pressed    = 1'b1;
        idle_cycles(8);                     // acted on within 6
        if (k == 4'(note_now())) begin
            cur_ofs = (song_len(cur_song) - cur_ofs <= 1) ? 0 : cur_ofs + 1;
        end else if (k == `KEY_PREV_SONG || k == `KEY_NEXT_SONG) begin
            cur_song = (k == `KEY_NEXT_SONG) ? (cur_song + 1) % 4 : (cur_song + 3) % 4;
            cur_ofs  = 0;
        end
    endtask

    task automatic key_up;
        is_pressed    = 1'b0;
        keyboard_data = 4'd0;
        idle_cycles(3);
    endtask

    task automatic press_key(input logic [3:0] k);
        key_down(k);
        key_up();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before && !timed_out) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests, name);
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int errs0;
        int n;
        int presses;
        sys_clk        = 1'b0;
        sys_rst_n      = 1'b0;
        init_done      = 1'b0;
        show_char_done = 1'b0;
        is_pressed     = 1'b0;
        keyboard_data  = 4'd0;
        scale          = 2'd0;
        cur_song       = 0;
        cur_ofs        = 0;
        exp_slot       = 0;
        lfsr           = 8'd31;
        errors         = 0;
        tests          = 0;
        tests_failed   = 0;
        timed_out      = 0;
        idle_cycles(10);
        sys_rst_n = 1'b1;

        errs0 = errors;
        repeat (6) begin
            next_cycle();
            assert ({show_char_flag, ascii_num, start_x, start_y} == '0 &&
                    background_color == `COLOR_WHITE && front_color == `COLOR_BLACK)
                else report_bad("reset outputs", 64'd0, {ascii_num, start_x, start_y});
        end
        init_done = 1'b1;
        wait_draw_request();
        repeat (3) begin
            n = 0;
            do begin
                next_cycle();
                n++;
            end while (!show_char_flag && n < 8);
            assert (n == 4) else report_bad("draw request spacing", 64'd4, 64'(n));
        end
        finish_test("reset and draw pulse", errs0);

        errs0 = errors;
        for (int scl = 0; scl < 3 && !timed_out; scl++) begin
            scale = 2'(scl);
            idle_cycles(2);
            scan_frame();
        end
        finish_test("frame glyphs and positions", errs0);

        errs0 = errors;
        scale = 2'd1;
        key_down(4'd3);
        scan_frame();
        key_up();
        scale = 2'd2;
        key_down(4'd7);
        scan_frame();
        key_up();
        scan_frame();                       // no key held so plain row colours
        finish_test("key highlight", errs0);

        errs0 = errors;
        scale = 2'd0;
        press_key(4'(note_now()));
        presses = 1;
        scan_frame();
        press_key(4'(note_now() % 7 + 1));  // wrong note
        scan_frame();
        while (presses < `SONG0_LEN && !timed_out) begin
            press_key(4'(note_now()));
            presses++;
        end
        scan_frame();
        finish_test("score progress", errs0);

        errs0 = errors;
        repeat (4) begin
            press_key(`KEY_NEXT_SONG);      // last step wraps 3 to 0
            scan_frame();
        end
        press_key(`KEY_PREV_SONG);
        scan_frame();
        finish_test("song select", errs0);

        $display("tests %0d, failed %0d, check errors %0d", tests, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
+incdir+test
source/menu_pkg.sv
source/score_view_if.sv
source/char_sequencer.sv
source/practice_tracker.sv
source/glyph_mapper.sv
source/char_style.sv
source/char_placement.sv
source/menu_show_top.sv
test/tb_menu_show.sv
